/* alu_unit.f */
hdl/alu_pkg.sv
hdl/add_sub.sv
hdl/booth_mul.sv
hdl/alu_cmd_fifo.sv
hdl/alu_exec.sv
hdl/alu_unit.sv
testbench/tb_clock_gen.sv
testbench/alu_unit_tb.sv

/* hdl/add_sub.sv */
`timescale 1ns/1ps

module add_sub
	import alu_pkg::*;
(
	input  logic [DATA_WIDTH-1:0]   a,
	input  logic [DATA_WIDTH-1:0]   b,
	input  logic                    signed_op, // 1 = treat operands as two's complement
	input  logic                    subtract,  // 1 = a - b
	output logic [2*DATA_WIDTH-1:0] sum
);

	logic [DATA_WIDTH:0] ext_a;  // one bit wider so no overflow is possible
	logic [DATA_WIDTH:0] ext_b;
	logic [DATA_WIDTH:0] opnd_b; // b or -b
	logic [DATA_WIDTH:0] res;    // 33-bit exact result

	always_comb begin
		// sign or zero extension by one bit
		ext_a = {signed_op & a[DATA_WIDTH-1], a};
		ext_b = {signed_op & b[DATA_WIDTH-1], b};

		// two's complement of b for subtract
		opnd_b = subtract ? (~ext_b + 1'b1) : ext_b;

		res = ext_a + opnd_b;

		// widen to the response width
		if (signed_op) begin
			sum = {{(DATA_WIDTH-1){res[DATA_WIDTH]}}, res}; // keep the sign
		end else begin
			sum = {{(DATA_WIDTH-1){1'b0}}, res}; // bit 32 is the carry
		end
	end

	// unsigned subtract is not an opcode, so the borrow case
	// (signed_op = 0, subtract = 1) is never selected from alu_exec

endmodule

/* hdl/alu_cmd_fifo.sv */
`timescale 1ns/1ps

module alu_cmd_fifo
	import alu_pkg::*;
#(
	parameter int CMD_DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,  // write din this edge
	input  alu_cmd_t din,
	input  logic     pop,   // drop head this edge
	output alu_cmd_t head,  // oldest entry, valid when !empty
	output logic     full,
	output logic     empty
);

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	alu_cmd_t         mem [CMD_DEPTH]; // storage only, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;           // entries held
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;  // push into a full buffer is lost
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= din;
	end

	// pointers wrap at CMD_DEPTH, works for any depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign head  = mem[rd_ptr];
	assign full  = (count == CNT_W'(CMD_DEPTH));
	assign empty = (count == '0);

	// source has to watch full
	a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
		else $error("alu_cmd_fifo: push while full, command dropped");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
		else $error("alu_cmd_fifo: pop while empty");

endmodule

/* hdl/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec
	import alu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  alu_cmd_t head,      // buffer head, valid while !empty
	input  logic     empty,
	output logic     pop,       // take head this cycle
	output logic     rsp_valid, // one-cycle pulse
	output alu_rsp_t rsp
);

	typedef enum logic {
		IDLE,
		MUL_WAIT
	} exec_state_t;

	exec_state_t             state;
	logic                    start;      // kicks the multiplier
	logic                    mul_done;
	logic [2*DATA_WIDTH-1:0] mul_product;
	logic [2*DATA_WIDTH-1:0] sum;        // add_sub output
	logic [2*DATA_WIDTH-1:0] comb_result;
	alu_op_t                 mul_op;     // opcode kept while multiplying

	assign pop   = (state == IDLE) && !empty;
	assign start = pop && (head.op == OP_MUL);

	// single adder, ops pick signedness and direction
	add_sub u_add_sub (
		.a        (head.a),
		.b        (head.b),
		.signed_op(head.op != OP_ADDU),
		.subtract (head.op == OP_SUB),
		.sum      (sum)
	);

	booth_mul u_booth_mul (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.multiplicand(head.a),
		.multiplier  (head.b),
		.done        (mul_done),
		.product     (mul_product)
	);

	always_comb begin
		case (head.op)
			OP_OR:                   comb_result = {{DATA_WIDTH{1'b0}}, head.a | head.b};
			OP_AND:                  comb_result = {{DATA_WIDTH{1'b0}}, head.a & head.b};
			OP_ADD, OP_SUB, OP_ADDU: comb_result = sum;
			default:                 comb_result = '0; // mul goes the slow way
		endcase
	end

	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				IDLE: if (pop) begin
					if (head.op == OP_MUL) state <= MUL_WAIT;
					else rsp_valid <= 1'b1; // one-cycle ops answer next cycle
				end
				MUL_WAIT: if (mul_done) begin
					state     <= IDLE;
					rsp_valid <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// response payload
	always_ff @(posedge clk) begin
		if (start) mul_op <= head.op;
		if (pop && !start) rsp <= '{op: head.op, result: comb_result};
		else if (state == MUL_WAIT && mul_done) rsp <= '{op: mul_op, result: mul_product};
	end

	// back-to-back pulses only when a single-cycle op was taken in between
	a_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |=> !rsp_valid || $past(pop && head.op != OP_MUL))
		else $error("alu_exec: rsp_valid held with no new command");

endmodule

/* hdl/alu_pkg.sv */
package alu_pkg;

	// operand width, shared by every struct below
	localparam int DATA_WIDTH = 32;

	// opcode encoding
	typedef enum logic [2:0] {
		OP_OR   = 3'd0, // bitwise or
		OP_AND  = 3'd1, // bitwise and
		OP_ADD  = 3'd2, // signed add
		OP_SUB  = 3'd3, // signed subtract
		OP_ADDU = 3'd4, // unsigned add, carry lands in bit 32
		OP_MUL  = 3'd5  // signed multiply, multi-cycle
	} alu_op_t;

	// command as pushed by the source
	// 3 + 32 + 32 = 67 bits
	typedef struct packed {
		alu_op_t               op; // what to do
		logic [DATA_WIDTH-1:0] a;  // first operand, multiplicand for OP_MUL
		logic [DATA_WIDTH-1:0] b;  // second operand, multiplier for OP_MUL
	} alu_cmd_t;

	// response handed back once per command
	// 3 + 64 = 67 bits
	typedef struct packed {
		alu_op_t                 op;     // opcode of the command that made it
		logic [2*DATA_WIDTH-1:0] result; // always double width, extended per op
	} alu_rsp_t;

	// result rules, for quick lookup
	//   or / and : zero-extended
	//   add / sub : 33-bit signed result, sign-extended
	//   addu : 33-bit unsigned result, zero-extended
	//   mul : full signed 64-bit product

	// opcodes 6 and 7 are free for later ops

endpackage

/* hdl/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit
	import alu_pkg::*;
#(
	parameter int CMD_DEPTH = 4 // command buffer entries
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     cmd_push,  // strobe, ignore full at your own risk
	input  alu_cmd_t cmd,
	output logic     full,      // stop pushing
	output logic     rsp_valid, // one pulse per finished command
	output alu_rsp_t rsp
);

	alu_cmd_t head;  // oldest queued command
	logic     empty;
	logic     pop;   // exec takes head

	alu_cmd_fifo #(
		.CMD_DEPTH(CMD_DEPTH)
	) u_cmd_fifo (
		.clk  (clk),
		.rst  (rst),
		.push (cmd_push),
		.din  (cmd),
		.pop  (pop),
		.head (head),
		.full (full),
		.empty(empty)
	);

	alu_exec u_exec (
		.clk      (clk),
		.rst      (rst),
		.head     (head),
		.empty    (empty),
		.pop      (pop),
		.rsp_valid(rsp_valid),
		.rsp      (rsp)
	);

endmodule

/* hdl/booth_mul.sv */
`timescale 1ns/1ps

module booth_mul
	import alu_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,        // one-cycle pulse, operands valid now
	input  logic [DATA_WIDTH-1:0]   multiplicand,
	input  logic [DATA_WIDTH-1:0]   multiplier,
	output logic                    done,         // one-cycle pulse, product ready
	output logic [2*DATA_WIDTH-1:0] product       // held until next start
);

	localparam int CNT_W = $clog2(DATA_WIDTH + 1);

	logic                  busy;   // steps in progress
	logic [CNT_W-1:0]      count;  // steps left
	logic [DATA_WIDTH:0]   acc;    // one extra bit so -(-2^31) fits
	logic [DATA_WIDTH-1:0] q;      // multiplier, shifts out as product low half fills
	logic                  q_1;    // booth look-behind bit
	logic [DATA_WIDTH:0]   mcand;  // sign-extended multiplicand
	logic [DATA_WIDTH:0]   acc_sel; // acc after add/sub, before shift

	// recode the current bit pair
	always_comb begin
		case ({q[0], q_1})
			2'b01:   acc_sel = acc + mcand; // end of a run of ones
			2'b10:   acc_sel = acc - mcand; // start of a run of ones
			default: acc_sel = acc;         // 00 or 11, nothing to add
		endcase
	end

	// control path
	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				count <= CNT_W'(DATA_WIDTH);
			end else if (busy) begin
				count <= count - 1'b1;
				if (count == CNT_W'(1)) begin // last step this edge
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// datapath, load on start then one step per cycle
	always_ff @(posedge clk) begin
		if (start) begin
			acc   <= '0;
			q     <= multiplier;
			q_1   <= 1'b0;
			mcand <= {multiplicand[DATA_WIDTH-1], multiplicand};
		end else if (busy) begin
			// arithmetic shift right of {acc, q, q_1}
			acc <= {acc_sel[DATA_WIDTH], acc_sel[DATA_WIDTH:1]};
			q   <= {acc_sel[0], q[DATA_WIDTH-1:1]};
			q_1 <= q[0];
		end
	end

	assign product = {acc[DATA_WIDTH-1:0], q}; // top acc bit is only a guard

	// exec must wait for done before the next multiply
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
		else $error("booth_mul: start while busy");

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the alu_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module alu_unit_tb -Mdir obj_dir -f alu_unit.f

./obj_dir/Valu_unit_tb | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
	echo "run_sim: simulation passed"
	exit 0
else
	echo "run_sim: simulation failed, see sim.log"
	exit 1
fi

/* testbench/alu_unit_tb.sv */
`timescale 1ns/1ps

module alu_unit_tb
	import alu_pkg::*;
();

	localparam int     N_TESTS     = 23;
	localparam int     CMD_DEPTH   = 4;
	localparam int     RST_CYCLES  = 16;
	localparam longint WATCHDOG_NS = (N_TESTS * (DATA_WIDTH + 4) + RST_CYCLES) * 20;

	logic     clk;
	logic     rst;
	logic     cmd_push;
	alu_cmd_t cmd;
	logic     full;
	logic     rsp_valid;
	alu_rsp_t rsp;

	string       tbl_name [N_TESTS];
	alu_cmd_t    tbl_cmd  [N_TESTS];
	alu_rsp_t    tbl_exp  [N_TESTS]; // expected response per entry
	int          n_tbl;
	int          exp_q[$];           // table indices in push order
	int          n_done;
	int          n_err;
	logic        full_seen;          // full went high at some point
	logic [31:0] lfsr_state;

	tb_clock_gen #(.PERIOD_NS(20)) u_clk (.clk(clk));

	alu_unit #(.CMD_DEPTH(CMD_DEPTH)) UUT (
		.clk      (clk),
		.rst      (rst),
		.cmd_push (cmd_push),
		.cmd      (cmd),
		.full     (full),
		.rsp_valid(rsp_valid),
		.rsp      (rsp)
	);

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			w = {w[30:0], lfsr_state[0]};
		end
	endtask

	// reference model in plain 64-bit arithmetic
	function automatic alu_rsp_t model_rsp(input alu_cmd_t c);
		longint      sa;
		longint      sb;
		longint      ua;
		longint      ub;
		logic [63:0] r;
		sa = $signed(c.a); // sign-extended to 64
		sb = $signed(c.b);
		ua = c.a;          // zero-extended to 64
		ub = c.b;
		case (c.op)
			OP_OR:   r = ua | ub;
			OP_AND:  r = ua & ub;
			OP_ADD:  r = sa + sb;
			OP_SUB:  r = sa - sb;
			OP_ADDU: r = ua + ub; // carry ends up in bit 32
			OP_MUL:  r = sa * sb;
			default: r = '0;
		endcase
		return '{op: c.op, result: r};
	endfunction

	task automatic add_entry(input string name, input alu_op_t op,
			input logic [31:0] a, input logic [31:0] b);
		tbl_name[n_tbl] = name;
		tbl_cmd[n_tbl]  = '{op: op, a: a, b: b};
		tbl_exp[n_tbl]  = model_rsp(tbl_cmd[n_tbl]);
		n_tbl++;
	endtask

	task automatic add_rand_entry(input string name, input alu_op_t op);
		logic [31:0] ra;
		logic [31:0] rb;
		rand_word(ra); // a drawn before b
		rand_word(rb);
		add_entry(name, op, ra, rb);
	endtask

	task automatic build_table();
		add_entry("or_fixed", OP_OR, 32'hF0F0_F0F0, 32'h0F0F_00FF);
		add_entry("and_fixed", OP_AND, 32'hFFFF_0000, 32'h0F0F_0F0F);
		add_rand_entry("or_rand", OP_OR);
		add_rand_entry("and_rand", OP_AND);
		add_entry("add_ovf", OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001); // stays positive
		add_entry("add_neg_ovf", OP_ADD, 32'h8000_0000, 32'hFFFF_FFFF);
		add_entry("sub_ovf", OP_SUB, 32'h8000_0000, 32'h0000_0001);
		add_entry("sub_pos_ovf", OP_SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
		add_rand_entry("add_rand", OP_ADD);
		add_rand_entry("sub_rand", OP_SUB);
		add_entry("addu_carry", OP_ADDU, 32'hFFFF_FFFF, 32'hFFFF_FFFF); // only bit 32 above
		add_rand_entry("addu_rand", OP_ADDU);
		add_entry("mul_mixed", OP_MUL, 32'hFFFF_FFF9, 32'h0001_E240); // -7 * 123456
		add_entry("mul_zero", OP_MUL, 32'h0000_0000, 32'hDEAD_BEEF);
		add_entry("mul_min_neg1", OP_MUL, 32'h8000_0000, 32'hFFFF_FFFF);
		add_entry("mul_min_sq", OP_MUL, 32'h8000_0000, 32'h8000_0000);
		add_rand_entry("mul_rand", OP_MUL);
		// tail of the burst, queue fills behind the multiplies
		add_rand_entry("burst_or", OP_OR);
		add_rand_entry("burst_add", OP_ADD);
		add_rand_entry("mul_rand_2", OP_MUL);
		add_rand_entry("burst_and", OP_AND);
		add_rand_entry("burst_addu", OP_ADDU);
		add_rand_entry("burst_sub", OP_SUB);
	endtask

	task automatic check_rsp(input string name, input alu_rsp_t exp, input alu_rsp_t act);
		if (act !== exp) begin
			n_err++;
			$display("mismatch %s: expected %s %h, actual %s %h",
				name, exp.op.name(), exp.result, act.op.name(), act.result);
		end else begin
			$display("ok %s: %s %h", name, act.op.name(), act.result);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			n_err++;
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
		end else begin
			$display("ok %s: %b", name, act);
		end
	endtask

	// outputs settle after the rising edge, look at them on the falling one
	always @(negedge clk) begin
		if (!rst && full) full_seen = 1'b1;
		if (!rst && rsp_valid) begin
			if (exp_q.size() == 0) begin
				n_err++;
				$display("error: response %s arrived with no command outstanding",
					rsp.op.name());
			end else begin
				check_rsp(tbl_name[exp_q[0]], tbl_exp[exp_q[0]], rsp);
				void'(exp_q.pop_front());
				n_done++;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("error: watchdog expired, %0d of %0d responses never arrived",
			n_tbl - n_done, n_tbl);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int i;
		rst        = 1'b1;
		cmd_push   = 1'b0;
		cmd        = '0;
		n_tbl      = 0;
		n_done     = 0;
		n_err      = 0;
		full_seen  = 1'b0;
		lfsr_state = 32'd22;
		build_table();
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst = 1'b0;
		@(negedge clk);
		check_flag("reset_full", 1'b0, full);
		check_flag("reset_rsp_valid", 1'b0, rsp_valid);
		i = 0;
		while (i < n_tbl) begin
			@(posedge clk);
			#2;
			if (full) begin
				cmd_push = 1'b0; // hold this entry until there is room
			end else begin
				cmd_push = 1'b1;
				cmd      = tbl_cmd[i];
				exp_q.push_back(i);
				i++;
			end
		end
		@(posedge clk);
		#2 cmd_push = 1'b0;
		wait (n_done == n_tbl);
		repeat (40) @(posedge clk); // quiet time to catch a duplicate
		check_flag("burst_full", 1'b1, full_seen);
		$display("%0d table tests, %0d responses, %0d errors", n_tbl, n_done, n_err);
		if (n_err == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 20 // full clock period
) (
	output logic clk
);

	initial clk = 1'b0; // low at time zero, first rising edge at half a period

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule
